/* logic/flit_link_pkg.sv */
package flit_link_pkg;

  typedef enum logic {
    FLIT_REQUEST  = 1'b0,
    FLIT_RESPONSE = 1'b1
  } flit_kind_t;

  // 0 and 3 are never legal kind codes on the wire
  typedef logic [1:0] ext_kind_t;

  localparam ext_kind_t EXT_KIND_REQUEST  = 2'd1;
  localparam ext_kind_t EXT_KIND_RESPONSE = 2'd2;

  localparam int FLIT_DATA_WIDTH      = 32;
  localparam int DEFAULT_CHANNELS     = 4;
  localparam int DEFAULT_BUFFER_DEPTH = 4;

  // internal word is {kind, head, tail, data}
  localparam int flit_word_width = 3 + FLIT_DATA_WIDTH;

  localparam int FLIT_KIND_POS = flit_word_width - 1;
  localparam int FLIT_HEAD_POS = flit_word_width - 2;
  localparam int FLIT_TAIL_POS = flit_word_width - 3;

  function automatic int vc_width(input int channels);
    return (channels > 1) ? $clog2(channels) : 1;
  endfunction

  function automatic logic ext_kind_is_valid(input ext_kind_t code);
    return (code == EXT_KIND_REQUEST) || (code == EXT_KIND_RESPONSE);
  endfunction

  function automatic flit_kind_t decode_kind(input ext_kind_t code);
    return (code == EXT_KIND_RESPONSE) ? FLIT_RESPONSE : FLIT_REQUEST;
  endfunction

  function automatic ext_kind_t encode_kind(input flit_kind_t kind);
    return (kind == FLIT_RESPONSE) ? EXT_KIND_RESPONSE : EXT_KIND_REQUEST;
  endfunction

  function automatic logic [flit_word_width-1:0] pack_flit(
    input flit_kind_t                 kind,
    input logic                       head,
    input logic                       tail,
    input logic [FLIT_DATA_WIDTH-1:0] data
  );
    logic [flit_word_width-1:0] word;
    word                = '0;
    word[FLIT_KIND_POS] = kind;
    word[FLIT_HEAD_POS] = head;
    word[FLIT_TAIL_POS] = tail;
    word[FLIT_DATA_WIDTH-1:0] = data;
    return word;
  endfunction

endpackage

/* logic/flit_ingress_converter.sv */
`timescale 1ns/1ps

module flit_ingress_converter #(
  parameter int CHANNELS = flit_link_pkg::DEFAULT_CHANNELS
)(
  input  logic                                                   clk,
  input  logic                                                   reset,
  input  logic [CHANNELS-1:0]                                    in_valid,
  input  flit_link_pkg::ext_kind_t [CHANNELS-1:0]                in_kind,
  input  logic [CHANNELS-1:0]                                    in_head,
  input  logic [CHANNELS-1:0]                                    in_tail,
  input  logic [CHANNELS-1:0][flit_link_pkg::FLIT_DATA_WIDTH-1:0] in_data,
  input  logic [CHANNELS-1:0]                                    buf_full,
  output logic [CHANNELS-1:0]                                    in_ready,
  output logic [CHANNELS-1:0]                                    wr_valid,
  output logic [CHANNELS-1:0][flit_link_pkg::flit_word_width-1:0] wr_flit,
  output logic [CHANNELS-1:0]                                    framing_error
);
  import flit_link_pkg::*;

  for (genvar i = 0; i < CHANNELS; i++) begin : g_chan
    logic                       stage_valid;
    logic [flit_word_width-1:0] stage_flit;
    logic                       error_q;
    logic                       in_packet; // a head has been seen without its tail
    logic                       accept;
    logic                       drain;
    logic                       bad_kind;
    logic                       bad_frame;
    logic                       good;

    assign drain  = stage_valid && !buf_full[i];
    assign accept = in_valid[i] && in_ready[i];

    assign bad_kind  = !ext_kind_is_valid(in_kind[i]);
    assign bad_frame = (in_head[i] && in_packet) || (!in_head[i] && !in_packet);
    assign good      = accept && !bad_kind && !bad_frame;

    // the stage can take a new flit when it is empty or moves into the FIFO this cycle
    assign in_ready[i]      = !stage_valid || !buf_full[i];
    assign wr_valid[i]      = stage_valid;
    assign wr_flit[i]       = stage_flit;
    assign framing_error[i] = error_q;

    always_ff @(posedge clk) begin
      if (reset) begin
        stage_valid <= 1'b0;
        in_packet   <= 1'b0;
        error_q     <= 1'b0;
      end else begin
        error_q <= accept && !good; // bad flits are swallowed here
        if (good) begin
          stage_valid <= 1'b1;
          in_packet   <= !in_tail[i]; // a single flit packet leaves it closed
        end else if (drain) begin
          stage_valid <= 1'b0;
        end
      end
    end

    always_ff @(posedge clk) begin
      if (good) begin
        stage_flit <= pack_flit(decode_kind(in_kind[i]), in_head[i], in_tail[i], in_data[i]);
      end
    end
  end

endmodule

/* logic/vc_flit_buffer.sv */
`timescale 1ns/1ps

module vc_flit_buffer #(
  parameter int DEPTH = flit_link_pkg::DEFAULT_BUFFER_DEPTH
)(
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      wr_valid,
  input  logic [flit_link_pkg::flit_word_width-1:0] wr_flit,
  input  logic                                      pop,
  output logic                                      full,
  output logic                                      rd_valid,
  output logic [flit_link_pkg::flit_word_width-1:0] rd_flit
);
  import flit_link_pkg::*;

  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  logic [flit_word_width-1:0] mem [DEPTH];
  logic [PTR_WIDTH-1:0]       wr_ptr;
  logic [PTR_WIDTH-1:0]       rd_ptr;
  logic [COUNT_WIDTH-1:0]     count;
  logic                       push;
  logic                       do_pop;

  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign rd_valid = (count != '0);
  assign rd_flit  = mem[rd_ptr];
  assign do_pop   = pop && rd_valid;

  // a pop in the same cycle frees the slot, so a full FIFO still takes a write
  assign full = (count == COUNT_WIDTH'(DEPTH)) && !do_pop;
  assign push = wr_valid && !full;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_flit;
    end
  end

endmodule

/* logic/vc_output_arbiter.sv */
`timescale 1ns/1ps

module vc_output_arbiter #(
  parameter  int CHANNELS = flit_link_pkg::DEFAULT_CHANNELS,
  localparam int VC_WIDTH = flit_link_pkg::vc_width(CHANNELS)
)(
  input  logic                                                   clk,
  input  logic                                                   reset,
  input  logic [CHANNELS-1:0]                                    rd_valid,
  input  logic [CHANNELS-1:0][flit_link_pkg::flit_word_width-1:0] rd_flit,
  input  logic [CHANNELS-1:0]                                    vc_available,
  input  logic                                                   sel_ready,
  output logic [CHANNELS-1:0]                                    pop,
  output logic                                                   sel_valid,
  output logic [VC_WIDTH-1:0]                                    sel_vc,
  output logic [flit_link_pkg::flit_word_width-1:0]              sel_flit
);

  logic [CHANNELS-1:0] eligible;
  logic [VC_WIDTH-1:0] rr_ptr; // first channel looked at in the next search
  logic                grant;

  // credit is checked here, at the grant
  assign eligible = rd_valid & vc_available;

  always_comb begin : search
    int idx;
    sel_valid = 1'b0;
    sel_vc    = '0;
    for (int k = 0; k < CHANNELS; k++) begin
      idx = int'(rr_ptr) + k;
      if (idx >= CHANNELS) begin
        idx = idx - CHANNELS;
      end
      if (!sel_valid && eligible[idx]) begin
        sel_valid = 1'b1;
        sel_vc    = VC_WIDTH'(idx);
      end
    end
  end

  assign grant    = sel_valid && sel_ready;
  assign sel_flit = rd_flit[sel_vc];

  always_comb begin
    pop = '0;
    if (grant) begin
      pop[sel_vc] = 1'b1;
    end
  end

  // the winner moves to the back of the line, so a waiting channel sees
  // at most CHANNELS-1 other grants
  always_ff @(posedge clk) begin
    if (reset) begin
      rr_ptr <= '0;
    end else if (grant) begin
      if (sel_vc == VC_WIDTH'(CHANNELS - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= sel_vc + 1'b1;
      end
    end
  end

endmodule

/* logic/flit_egress_converter.sv */
`timescale 1ns/1ps

module flit_egress_converter #(
  parameter  int CHANNELS = flit_link_pkg::DEFAULT_CHANNELS,
  localparam int VC_WIDTH = flit_link_pkg::vc_width(CHANNELS)
)(
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      sel_valid,
  input  logic [VC_WIDTH-1:0]                       sel_vc,
  input  logic [flit_link_pkg::flit_word_width-1:0] sel_flit,
  input  logic                                      out_ready,
  output logic                                      sel_ready,
  output logic                                      out_valid,
  output logic [VC_WIDTH-1:0]                       out_vc,
  output flit_link_pkg::ext_kind_t                  out_kind,
  output logic                                      out_head,
  output logic                                      out_tail,
  output logic [flit_link_pkg::FLIT_DATA_WIDTH-1:0] out_data
);
  import flit_link_pkg::*;

  logic load;

  // the register is free when it is empty or its flit leaves this cycle
  assign sel_ready = !out_valid || out_ready;
  assign load      = sel_valid && sel_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // fields only change on a load, so they hold while out_ready is low
  always_ff @(posedge clk) begin
    if (load) begin
      out_vc   <= sel_vc;
      out_kind <= encode_kind(flit_kind_t'(sel_flit[FLIT_KIND_POS]));
      out_head <= sel_flit[FLIT_HEAD_POS];
      out_tail <= sel_flit[FLIT_TAIL_POS];
      out_data <= sel_flit[FLIT_DATA_WIDTH-1:0];
    end
  end

endmodule

/* logic/flit_link_top.sv */
`timescale 1ns/1ps

module flit_link_top #(
  parameter  int CHANNELS     = flit_link_pkg::DEFAULT_CHANNELS,
  parameter  int BUFFER_DEPTH = flit_link_pkg::DEFAULT_BUFFER_DEPTH,
  localparam int VC_WIDTH     = flit_link_pkg::vc_width(CHANNELS)
)(
  input  logic                                                   clk,
  input  logic                                                   reset,
  input  logic [CHANNELS-1:0]                                    in_valid,
  output logic [CHANNELS-1:0]                                    in_ready,
  input  flit_link_pkg::ext_kind_t [CHANNELS-1:0]                in_kind,
  input  logic [CHANNELS-1:0]                                    in_head,
  input  logic [CHANNELS-1:0]                                    in_tail,
  input  logic [CHANNELS-1:0][flit_link_pkg::FLIT_DATA_WIDTH-1:0] in_data,
  output logic [CHANNELS-1:0]                                    framing_error,
  output logic                                                   out_valid,
  input  logic                                                   out_ready,
  output logic [VC_WIDTH-1:0]                                    out_vc,
  output flit_link_pkg::ext_kind_t                               out_kind,
  output logic                                                   out_head,
  output logic                                                   out_tail,
  output logic [flit_link_pkg::FLIT_DATA_WIDTH-1:0]              out_data,
  input  logic [CHANNELS-1:0]                                    out_vc_available
);
  import flit_link_pkg::*;

  logic [CHANNELS-1:0]                      wr_valid;
  logic [CHANNELS-1:0][flit_word_width-1:0] wr_flit;
  logic [CHANNELS-1:0]                      buf_full;
  logic [CHANNELS-1:0]                      rd_valid;
  logic [CHANNELS-1:0][flit_word_width-1:0] rd_flit;
  logic [CHANNELS-1:0]                      pop;
  logic                                     sel_valid;
  logic                                     sel_ready;
  logic [VC_WIDTH-1:0]                      sel_vc;
  logic [flit_word_width-1:0]               sel_flit;

  flit_ingress_converter #(
    .CHANNELS (CHANNELS)
  ) ingress_i (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .in_kind       (in_kind),
    .in_head       (in_head),
    .in_tail       (in_tail),
    .in_data       (in_data),
    .buf_full      (buf_full),
    .in_ready      (in_ready),
    .wr_valid      (wr_valid),
    .wr_flit       (wr_flit),
    .framing_error (framing_error)
  );

  for (genvar i = 0; i < CHANNELS; i++) begin : g_buf
    vc_flit_buffer #(
      .DEPTH (BUFFER_DEPTH)
    ) buffer_i (
      .clk      (clk),
      .reset    (reset),
      .wr_valid (wr_valid[i]),
      .wr_flit  (wr_flit[i]),
      .pop      (pop[i]),
      .full     (buf_full[i]),
      .rd_valid (rd_valid[i]),
      .rd_flit  (rd_flit[i])
    );
  end

  vc_output_arbiter #(
    .CHANNELS (CHANNELS)
  ) arbiter_i (
    .clk          (clk),
    .reset        (reset),
    .rd_valid     (rd_valid),
    .rd_flit      (rd_flit),
    .vc_available (out_vc_available),
    .sel_ready    (sel_ready),
    .pop          (pop),
    .sel_valid    (sel_valid),
    .sel_vc       (sel_vc),
    .sel_flit     (sel_flit)
  );

  flit_egress_converter #(
    .CHANNELS (CHANNELS)
  ) egress_i (
    .clk       (clk),
    .reset     (reset),
    .sel_valid (sel_valid),
    .sel_vc    (sel_vc),
    .sel_flit  (sel_flit),
    .out_ready (out_ready),
    .sel_ready (sel_ready),
    .out_valid (out_valid),
    .out_vc    (out_vc),
    .out_kind  (out_kind),
    .out_head  (out_head),
    .out_tail  (out_tail),
    .out_data  (out_data)
  );

endmodule

/* bench/flit_link_tb.sv */
`timescale 1ns/1ps

module flit_link_tb;
  import flit_link_pkg::*;

  localparam int CHANNELS     = 4;
  localparam int BUFFER_DEPTH = 4;
  localparam int VC_WIDTH     = vc_width(CHANNELS);
  localparam int ENTRY_W      = 4 + FLIT_DATA_WIDTH; // {kind code, head, tail, data}
  localparam int FIELD_W      = VC_WIDTH + ENTRY_W;
  localparam int IDLE_LIMIT   = 50;
  localparam int DRAIN_LIMIT  = 2000;

  logic                                     clk;
  logic                                     reset;
  logic [CHANNELS-1:0]                      in_valid;
  logic [CHANNELS-1:0]                      in_ready;
  ext_kind_t [CHANNELS-1:0]                 in_kind;
  logic [CHANNELS-1:0]                      in_head;
  logic [CHANNELS-1:0]                      in_tail;
  logic [CHANNELS-1:0][FLIT_DATA_WIDTH-1:0] in_data;
  logic [CHANNELS-1:0]                      framing_error;
  logic                                     out_valid;
  logic                                     out_ready;
  logic [VC_WIDTH-1:0]                      out_vc;
  ext_kind_t                                out_kind;
  logic                                     out_head;
  logic                                     out_tail;
  logic [FLIT_DATA_WIDTH-1:0]               out_data;
  logic [CHANNELS-1:0]                      out_vc_available;

  logic [31:0]         rng_state;
  logic [CHANNELS-1:0] drv_open;   // packet state as the driver sends it
  logic [CHANNELS-1:0] model_open; // packet state rebuilt from accepted flits
  logic [CHANNELS-1:0] flit_take;
  logic [CHANNELS-1:0] flit_bad;
  logic [CHANNELS-1:0] bad_q;
  int                  exp_vc[$];
  logic [ENTRY_W-1:0]  exp_flit[$];
  logic                fair_check;
  int                  skip_count [CHANNELS];
  logic                prev_valid;
  logic                prev_ready;
  logic                prev_stall;
  logic [CHANNELS-1:0] prev_avail;
  logic [FIELD_W-1:0]  prev_fields;
  int                  error_count;
  int                  errors_at_start;
  int                  tests_run;
  int                  tests_failed;

  flit_link_top #(
    .CHANNELS     (CHANNELS),
    .BUFFER_DEPTH (BUFFER_DEPTH)
  ) dut_i (
    .clk              (clk),
    .reset            (reset),
    .in_valid         (in_valid),
    .in_ready         (in_ready),
    .in_kind          (in_kind),
    .in_head          (in_head),
    .in_tail          (in_tail),
    .in_data          (in_data),
    .framing_error    (framing_error),
    .out_valid        (out_valid),
    .out_ready        (out_ready),
    .out_vc           (out_vc),
    .out_kind         (out_kind),
    .out_head         (out_head),
    .out_tail         (out_tail),
    .out_data         (out_data),
    .out_vc_available (out_vc_available)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  always_comb begin
    for (int i = 0; i < CHANNELS; i++) begin
      flit_take[i] = in_valid[i] && in_ready[i];
      // legal codes are 1 and 2, and only a flit that opens a packet may carry a head
      flit_bad[i] = flit_take[i] && ((in_kind[i] != 2'd1 && in_kind[i] != 2'd2) ||
                                     (in_head[i] == model_open[i]));
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("ERROR %0t %s expected %h got %h", $time, name, expected, actual);
    error_count++;
  endtask

  task automatic compare_output();
    int                 pos;
    logic [ENTRY_W-1:0] exp;
    pos = -1;
    for (int k = 0; k < exp_vc.size(); k++) begin
      if (pos < 0 && exp_vc[k] == int'(out_vc)) begin
        pos = k;
      end
    end
    assert (pos >= 0) else begin
      $display("%0t: a flit left on channel %0d with nothing expected there", $time, out_vc);
      error_count++;
    end
    if (pos >= 0) begin
      exp = exp_flit[pos]; // oldest flit of this channel
      exp_vc.delete(pos);
      exp_flit.delete(pos);
      assert (out_kind == exp[ENTRY_W-1:ENTRY_W-2])
        else report_mismatch("out_kind", 32'(exp[ENTRY_W-1:ENTRY_W-2]), 32'(out_kind));
      assert (out_head == exp[ENTRY_W-3])
        else report_mismatch("out_head", 32'(exp[ENTRY_W-3]), 32'(out_head));
      assert (out_tail == exp[ENTRY_W-4])
        else report_mismatch("out_tail", 32'(exp[ENTRY_W-4]), 32'(out_tail));
      assert (out_data == exp[FLIT_DATA_WIDTH-1:0])
        else report_mismatch("out_data", exp[FLIT_DATA_WIDTH-1:0], out_data);
    end
  endtask

  always @(posedge clk) begin : scoreboard
    int pending [CHANNELS];
    for (int i = 0; i < CHANNELS; i++) begin
      pending[i] = 0;
    end
    for (int k = 0; k < exp_vc.size(); k++) begin
      pending[exp_vc[k]]++;
    end
    if (reset) begin
      model_open <= '0;
      bad_q      <= '0;
      for (int i = 0; i < CHANNELS; i++) begin
        skip_count[i] <= 0;
      end
    end else begin
      bad_q <= flit_bad;
      for (int i = 0; i < CHANNELS; i++) begin
        if (flit_take[i] && !flit_bad[i]) begin
          exp_vc.push_back(i);
          exp_flit.push_back({in_kind[i], in_head[i], in_tail[i], in_data[i]});
          model_open[i] <= !in_tail[i];
        end
        if (!fair_check) begin
          skip_count[i] <= 0;
        end else if (out_valid && out_ready) begin
          if (i == int'(out_vc)) begin
            skip_count[i] <= 0;
          end else if (pending[i] > 0) begin
            skip_count[i] <= skip_count[i] + 1; // another channel went first
          end
        end
      end
      if (out_valid && out_ready) begin
        compare_output();
      end
    end
  end

  always @(posedge clk) begin
    prev_valid  <= out_valid;
    prev_ready  <= out_ready;
    prev_avail  <= out_vc_available;
    prev_stall  <= out_valid && !out_ready;
    prev_fields <= {out_vc, out_kind, out_head, out_tail, out_data};
  end

  assert property (@(posedge clk) disable iff (reset)
    prev_stall |-> (out_valid && {out_vc, out_kind, out_head, out_tail, out_data} == prev_fields))
    else begin
      $display("%0t: output flit changed or vanished while out_ready was low", $time);
      error_count++;
    end

  // a freshly loaded output flit was granted at the previous edge
  assert property (@(posedge clk) disable iff (reset)
    (out_valid && (!prev_valid || prev_ready)) |-> prev_avail[out_vc])
    else begin
      $display("ERROR %0t out_vc_available[%0d] expected 1 got 0", $time, out_vc);
      error_count++;
    end

  for (genvar g = 0; g < CHANNELS; g++) begin : g_lane
    assert property (@(posedge clk) disable iff (reset) framing_error[g] == bad_q[g])
      else begin
        $display("ERROR %0t framing_error[%0d] expected %b got %b",
                 $time, g, bad_q[g], framing_error[g]);
        error_count++;
      end
    assert property (@(posedge clk) disable iff (reset) fair_check |-> skip_count[g] < CHANNELS)
      else begin
        $display("%0t: channel %0d waited behind %0d other transfers", $time, g, skip_count[g]);
        error_count++;
      end
  end

  task automatic abort_run(input string why);
    $display("%0t: %s", $time, why);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (error_count == errors_at_start) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, error_count - errors_at_start);
    end
    errors_at_start = error_count;
  endtask

  // ready_mode 0 holds out_ready low, 1 holds it high, 2 randomizes it
  task automatic run_traffic(input int cycles, input int load, input int bad,
                             input int ready_mode, input bit avail_random);
    logic [31:0] r;
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk);
      rng_state = xorshift32(rng_state);
      case (ready_mode)
        0:       out_ready <= 1'b0;
        1:       out_ready <= 1'b1;
        default: out_ready <= (rng_state[1:0] != 2'b00);
      endcase
      if (avail_random) begin
        out_vc_available <= rng_state[8 +: CHANNELS];
      end
      for (int i = 0; i < CHANNELS; i++) begin
        if (!in_valid[i] || in_ready[i]) begin
          rng_state = xorshift32(rng_state);
          r = rng_state;
          rng_state = xorshift32(rng_state);
          if (int'(r[3:0]) < load) begin
            in_valid[i] <= 1'b1;
            in_data[i]  <= rng_state;
            in_tail[i]  <= r[10];
            if (int'(r[7:4]) < bad) begin
              if (r[8]) begin
                in_kind[i] <= r[9] ? 2'd3 : 2'd0;
                in_head[i] <= !drv_open[i];
              end else begin
                in_kind[i] <= r[11] ? 2'd2 : 2'd1;
                in_head[i] <= drv_open[i]; // head where the framing forbids it
              end
            end else begin
              in_kind[i]  <= r[11] ? 2'd2 : 2'd1;
              in_head[i]  <= !drv_open[i];
              drv_open[i] = !r[10];
            end
          end else begin
            in_valid[i] <= 1'b0;
          end
        end
      end
    end
  endtask

  task automatic drain_queues();
    int cycles;
    bit done;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      out_ready        <= 1'b1;
      out_vc_available <= '1;
      for (int i = 0; i < CHANNELS; i++) begin
        if (in_ready[i]) begin
          in_valid[i] <= 1'b0;
        end
      end
      @(negedge clk);
      done = (in_valid == '0) && (exp_vc.size() == 0);
      cycles++;
    end
    if (!done) begin
      abort_run("the channel queues did not drain");
    end
  endtask

  initial begin : main
    int waited;
    reset            <= 1'b1;
    in_valid         <= '0;
    in_kind          <= '0;
    in_head          <= '0;
    in_tail          <= '0;
    in_data          <= '0;
    out_ready        <= 1'b0;
    out_vc_available <= '1;
    rng_state        = 32'd48;
    drv_open         = '0;
    fair_check       <= 1'b0;
    error_count      = 0;
    errors_at_start  = 0;
    tests_run        = 0;
    tests_failed     = 0;

    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (out_valid == 1'b0) else report_mismatch("out_valid", 32'd0, 32'(out_valid));
    assert (framing_error == '0)
      else report_mismatch("framing_error", 32'd0, 32'(framing_error));
    waited = 0;
    while (in_ready != '1 && waited < IDLE_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (in_ready != '1) begin
      abort_run("in_ready did not rise after reset");
    end
    end_test("reset state");

    run_traffic(300, 10, 0, 2, 1'b0);
    drain_queues();
    end_test("clean traffic");

    run_traffic(300, 10, 5, 2, 1'b0);
    drain_queues();
    end_test("framing errors");

    run_traffic(300, 12, 2, 2, 1'b1);
    drain_queues();
    end_test("credit gating");

    run_traffic(40, 12, 0, 0, 1'b0);
    drain_queues();
    end_test("output stall");

    run_traffic(30, 16, 0, 0, 1'b0); // every channel backs up behind the stall
    fair_check <= 1'b1;
    drain_queues();
    fair_check <= 1'b0;
    end_test("round robin fairness");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
logic/flit_link_pkg.sv
logic/flit_ingress_converter.sv
logic/vc_flit_buffer.sv
logic/vc_output_arbiter.sv
logic/flit_egress_converter.sv
logic/flit_link_top.sv
bench/flit_link_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench, then decide on the log contents
rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module flit_link_tb -f verilog.f -o flit_link_sim &&
./obj_dir/flit_link_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
